/* rtl/core_regs_pkg.sv */
/*
 * core register map
 * bridge addresses, field widths and reset values for the control registers,
 * plus the two-view bridge address type
 */
`default_nettype none

package core_regs_pkg;

    // field widths
    localparam int DATA_WIDTH  = 32;
    localparam int POS_WIDTH   = 10;
    localparam int FRAME_WIDTH = 16;
    localparam int CHAN_WIDTH  = 3;

    ////////////////////
    // register map

    // square window 0x002000xx, upper 24 bits only
    localparam logic [23:0] ADDR_SQUARE_WIN = 24'h002000;
    localparam logic [7:0]  OFFS_SQUARE_X   = 8'h00;
    localparam logic [7:0]  OFFS_SQUARE_Y   = 8'h04;

    localparam logic [31:0] ADDR_ANIM_EN        = 32'h0010_0000;
    localparam logic [31:0] ADDR_DEBUG          = 32'h0010_0004;
    localparam logic [31:0] ADDR_SIGNED         = 32'h0030_0000;
    localparam logic [31:0] ADDR_CHAN_EN        = 32'h00F0_000C;
    // command addresses, write only
    localparam logic [31:0] ADDR_CMD_SQUARE_RST = 32'h00F0_0010;
    localparam logic [31:0] ADDR_CMD_FRAME_RST  = 32'h00F0_0014;
    localparam logic [31:0] ADDR_CMD_FRAME_INC  = 32'h00F0_0018;
    localparam logic [31:0] ADDR_FRAME_COUNT    = 32'h2000_0000;

    ////////////////////
    // reset values

    localparam logic [CHAN_WIDTH-1:0] CHAN_EN_RESET = 3'b111;
    localparam logic                  ANIM_EN_RESET = 1'b1;
    localparam logic [DATA_WIDTH-1:0] DEBUG_RESET   = 32'h1200_5678;

    // bridge address, exact match view or window/offset view
    typedef union packed {
        logic [31:0] full;
        struct packed {
            logic [23:0] win;
            logic [7:0]  offs;
        } win_view;
    } bridge_addr_u;

endpackage

`default_nettype wire

/* rtl/core_audio_pkg.sv */
/*
 * audio clocking constants
 * fractional MCLK accumulator for a 74.25 MHz reference and the I2S framing
 */
`default_nettype none

package core_audio_pkg;

    // 74.25 MHz * 245760 / (2 * 742500) = 12.288 MHz mclk
    localparam logic [21:0] MCLK_STEP = 22'd245760;
    localparam logic [21:0] MCLK_WRAP = 22'd742500;

    // mclk periods per sclk period
    localparam int SCLK_DIV = 4;
    // sclk periods per lrck half period
    localparam int BITS_PER_CHANNEL = 32;

endpackage

`default_nettype wire

/* rtl/bridge_decode.sv */
/*
 * bridge decode, register pipeline stage 1
 * registers each bridge access and turns its address into one-hot selects
 */
`default_nettype none

module bridge_decode import core_regs_pkg::*; (
    input  logic                  clk_74a,
    input  logic                  rst_n,
    input  logic [31:0]           bridge_addr,
    input  logic                  bridge_rd,
    input  logic                  bridge_wr,
    input  logic [DATA_WIDTH-1:0] bridge_wr_data,
    output logic                  wr_valid,
    output logic                  rd_valid,
    output logic [DATA_WIDTH-1:0] wr_data,
    output logic                  sel_square_x,
    output logic                  sel_square_y,
    output logic                  sel_chan_en,
    output logic                  sel_anim_en,
    output logic                  sel_debug,
    output logic                  sel_signed,
    output logic                  sel_frame_count,
    output logic                  sel_cmd_square_rst,
    output logic                  sel_cmd_frame_rst,
    output logic                  sel_cmd_frame_inc
);

    bridge_addr_u addr;
    logic         in_win;
    logic         offs_x;
    logic         offs_y;

    assign addr = bridge_addr;

    // square window hit and offset checks
    assign in_win = (addr.win_view.win == ADDR_SQUARE_WIN);
    assign offs_x = (addr.win_view.offs == OFFS_SQUARE_X);
    assign offs_y = (addr.win_view.offs == OFFS_SQUARE_Y);

    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid           <= 1'b0;
            rd_valid           <= 1'b0;
            sel_square_x       <= 1'b0;
            sel_square_y       <= 1'b0;
            sel_chan_en        <= 1'b0;
            sel_anim_en        <= 1'b0;
            sel_debug          <= 1'b0;
            sel_signed         <= 1'b0;
            sel_frame_count    <= 1'b0;
            sel_cmd_square_rst <= 1'b0;
            sel_cmd_frame_rst  <= 1'b0;
            sel_cmd_frame_inc  <= 1'b0;
        end else begin
            wr_valid <= bridge_wr;
            rd_valid <= bridge_rd;
            // reads: any offset but y gives x; writes: only offset 0 hits x
            sel_square_x       <= in_win && (bridge_rd ? !offs_y : offs_x);
            sel_square_y       <= in_win && offs_y;
            sel_chan_en        <= (addr.full == ADDR_CHAN_EN);
            sel_anim_en        <= (addr.full == ADDR_ANIM_EN);
            sel_debug          <= (addr.full == ADDR_DEBUG);
            sel_signed         <= (addr.full == ADDR_SIGNED);
            sel_frame_count    <= (addr.full == ADDR_FRAME_COUNT);
            sel_cmd_square_rst <= (addr.full == ADDR_CMD_SQUARE_RST);
            sel_cmd_frame_rst  <= (addr.full == ADDR_CMD_FRAME_RST);
            sel_cmd_frame_inc  <= (addr.full == ADDR_CMD_FRAME_INC);
        end
    end

    // write data only matters alongside wr_valid
    always_ff @(posedge clk_74a) begin
        wr_data <= bridge_wr_data;
    end

endmodule

`default_nettype wire

/* rtl/ctrl_regs.sv */
/*
 * control registers, register pipeline stage 2
 * holds channel/animation enables and the debug and signed words, turns
 * square and command writes into single-cycle pulses, registers read data
 */
`default_nettype none

module ctrl_regs import core_regs_pkg::*; (
    input  logic                   clk_74a,
    input  logic                   rst_n,
    // from stage 1
    input  logic                   wr_valid,
    input  logic                   rd_valid,
    input  logic [DATA_WIDTH-1:0]  wr_data,
    input  logic                   sel_square_x,
    input  logic                   sel_square_y,
    input  logic                   sel_chan_en,
    input  logic                   sel_anim_en,
    input  logic                   sel_debug,
    input  logic                   sel_signed,
    input  logic                   sel_frame_count,
    input  logic                   sel_cmd_square_rst,
    input  logic                   sel_cmd_frame_rst,
    input  logic                   sel_cmd_frame_inc,
    // from stage 3
    input  logic [POS_WIDTH-1:0]   square_x,
    input  logic [POS_WIDTH-1:0]   square_y,
    input  logic [FRAME_WIDTH-1:0] frame_count,
    output logic [DATA_WIDTH-1:0]  bridge_rd_data,
    // to stage 3
    output logic                   square_x_wr,
    output logic                   square_y_wr,
    output logic                   square_rst,
    output logic                   frame_rst,
    output logic                   frame_inc,
    output logic [POS_WIDTH-1:0]   pos_data,
    output logic                   anim_en,
    output logic [CHAN_WIDTH-1:0]  chan_en
);

    logic [DATA_WIDTH-1:0] debug_value;
    logic [DATA_WIDTH-1:0] signed_value;
    logic [DATA_WIDTH-1:0] rd_word;

    ////////////////////
    // register writes and command pulses

    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            chan_en      <= CHAN_EN_RESET;
            anim_en      <= ANIM_EN_RESET;
            debug_value  <= DEBUG_RESET;
            signed_value <= '0;
            square_x_wr  <= 1'b0;
            square_y_wr  <= 1'b0;
            square_rst   <= 1'b0;
            frame_rst    <= 1'b0;
            frame_inc    <= 1'b0;
        end else begin
            if (wr_valid && sel_chan_en) chan_en <= wr_data[CHAN_WIDTH-1:0];
            if (wr_valid && sel_anim_en) anim_en <= wr_data[0];
            if (wr_valid && sel_debug) debug_value <= wr_data;
            if (wr_valid && sel_signed) signed_value <= wr_data;
            // one cycle each, stage 3 acts on them
            square_x_wr <= wr_valid && sel_square_x;
            square_y_wr <= wr_valid && sel_square_y;
            square_rst  <= wr_valid && sel_cmd_square_rst;
            frame_rst   <= wr_valid && sel_cmd_frame_rst;
            frame_inc   <= wr_valid && sel_cmd_frame_inc;
        end
    end

    // position payload travels with the x/y pulses
    always_ff @(posedge clk_74a) begin
        pos_data <= wr_data[POS_WIDTH-1:0];
    end

    ////////////////////
    // read-back mux

    // selects are one-hot, unmapped reads fall through to 0
    always_comb begin
        rd_word = '0;
        if (sel_square_x) rd_word = DATA_WIDTH'(square_x);
        if (sel_square_y) rd_word = DATA_WIDTH'(square_y);
        if (sel_chan_en) rd_word = DATA_WIDTH'(chan_en);
        if (sel_anim_en) rd_word = DATA_WIDTH'(anim_en);
        if (sel_debug) rd_word = debug_value;
        if (sel_signed) rd_word = signed_value;
        if (sel_frame_count) rd_word = DATA_WIDTH'(frame_count);
    end

    // holds until the next read lands
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            bridge_rd_data <= '0;
        end else if (rd_valid) begin
            bridge_rd_data <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* rtl/frame_state.sv */
/*
 * frame state, register pipeline stage 3
 * square position and the vblank-driven frame counter
 */
`default_nettype none

module frame_state import core_regs_pkg::*; #(
    parameter int FRAME_WIDTH = core_regs_pkg::FRAME_WIDTH
) (
    input  logic                   clk_74a,
    input  logic                   rst_n,
    input  logic                   vblank,
    input  logic                   anim_en,
    input  logic                   square_x_wr,
    input  logic                   square_y_wr,
    input  logic                   square_rst,
    input  logic                   frame_rst,
    input  logic                   frame_inc,
    input  logic [POS_WIDTH-1:0]   pos_data,
    output logic [POS_WIDTH-1:0]   square_x,
    output logic [POS_WIDTH-1:0]   square_y,
    output logic [FRAME_WIDTH-1:0] frame_count
);

    logic vblank_q;
    logic vblank_rise;

    // single-register edge detect
    assign vblank_rise = vblank && !vblank_q;

    ////////////////////
    // square position

    // reset command beats a same-cycle write
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            square_x <= '0;
            square_y <= '0;
        end else if (square_rst) begin
            square_x <= '0;
            square_y <= '0;
        end else begin
            if (square_x_wr) square_x <= pos_data;
            if (square_y_wr) square_y <= pos_data;
        end
    end

    ////////////////////
    // frame counter

    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            vblank_q    <= 1'b0;
            frame_count <= '0;
        end else begin
            vblank_q <= vblank;
            // frame_rst wins, else command and vblank both count, wraps
            if (frame_rst) begin
                frame_count <= '0;
            end else begin
                frame_count <= frame_count + FRAME_WIDTH'(frame_inc)
                             + FRAME_WIDTH'(vblank_rise && anim_en);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/audio_clock_gen.sv */
/*
 * I2S silence generator
 * fractional accumulator MCLK, SCLK and LRCK counted from MCLK edges,
 * DAC data held low
 */
`default_nettype none

module audio_clock_gen import core_audio_pkg::*; #(
    parameter logic [21:0] ACCUM_STEP = MCLK_STEP,
    parameter logic [21:0] ACCUM_WRAP = MCLK_WRAP
) (
    input  logic clk_74a,
    input  logic rst_n,
    output logic audio_mclk,
    output logic audio_lrck,
    output logic audio_dac
);

    localparam int DIV_W = $clog2(SCLK_DIV);
    localparam int BIT_W = $clog2(BITS_PER_CHANNEL);

    logic [$bits(ACCUM_STEP)-1:0] accum;
    logic                         mclk_toggle;
    logic                         mclk_rise;
    logic                         sclk_fall;
    logic [DIV_W-1:0]             sclk_div;
    logic [BIT_W-1:0]             bit_cnt;

    assign mclk_toggle = (accum >= ACCUM_WRAP);
    // toggling from low means a rising edge this clock
    assign mclk_rise   = mclk_toggle && !audio_mclk;
    // sclk is the divider msb, it falls as the divider wraps
    assign sclk_fall   = mclk_rise && (sclk_div == DIV_W'(SCLK_DIV - 1));

    ////////////////////
    // mclk accumulator

    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            accum      <= '0;
            audio_mclk <= 1'b0;
        end else if (mclk_toggle) begin
            accum      <= accum - ACCUM_WRAP + ACCUM_STEP;
            audio_mclk <= !audio_mclk;
        end else begin
            accum <= accum + ACCUM_STEP;
        end
    end

    ////////////////////
    // sclk divide and lrck framing

    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            sclk_div   <= '0;
            bit_cnt    <= '0;
            audio_lrck <= 1'b0;
        end else begin
            if (mclk_rise) sclk_div <= sclk_div + 1'b1;
            if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
                // switch channel after the last bit slot
                if (bit_cnt == BIT_W'(BITS_PER_CHANNEL - 1)) begin
                    audio_lrck <= !audio_lrck;
                    bit_cnt    <= '0;
                end
            end
        end
    end

    // silence
    assign audio_dac = 1'b0;

endmodule

`default_nettype wire

/* rtl/core_top.sv */
/*
 * core top level
 * bridge register pipeline (decode, control, frame state) and audio clocks
 */
`default_nettype none

module core_top import core_regs_pkg::*, core_audio_pkg::*; (
    input  logic                  clk_74a,
    input  logic                  rst_n,
    input  logic [31:0]           bridge_addr,
    input  logic                  bridge_rd,
    input  logic                  bridge_wr,
    input  logic [DATA_WIDTH-1:0] bridge_wr_data,
    input  logic                  vblank,
    output logic [DATA_WIDTH-1:0] bridge_rd_data,
    output logic [CHAN_WIDTH-1:0] video_channel_enable,
    output logic                  video_anim_enable,
    output logic                  audio_mclk,
    output logic                  audio_lrck,
    output logic                  audio_dac
);

    // stage 1 to 2
    logic                   wr_valid, rd_valid;
    logic [DATA_WIDTH-1:0]  wr_data;
    logic                   sel_square_x, sel_square_y, sel_chan_en, sel_anim_en;
    logic                   sel_debug, sel_signed, sel_frame_count;
    logic                   sel_cmd_square_rst, sel_cmd_frame_rst, sel_cmd_frame_inc;
    // stage 2 to 3 and back
    logic                   square_x_wr, square_y_wr, square_rst, frame_rst, frame_inc;
    logic [POS_WIDTH-1:0]   pos_data, square_x, square_y;
    logic [FRAME_WIDTH-1:0] frame_count;

    bridge_decode bridge_decode_inst (.*);

    ctrl_regs ctrl_regs_inst (
        .*,
        .anim_en (video_anim_enable),
        .chan_en (video_channel_enable)
    );

    frame_state #(
        .FRAME_WIDTH (FRAME_WIDTH)
    ) frame_state_inst (
        .*,
        .anim_en (video_anim_enable)
    );

    audio_clock_gen #(
        .ACCUM_STEP (MCLK_STEP),
        .ACCUM_WRAP (MCLK_WRAP)
    ) audio_clock_gen_inst (.*);

endmodule

`default_nettype wire

/* dv/core_top_properties.sv */
/*
 * core_top properties
 * host bridge rule, silent DAC data and channel enable write timing
 */
`default_nettype none

module core_top_properties import core_regs_pkg::*; (
    input logic                  clk_74a,
    input logic                  rst_n,
    input logic                  bridge_rd,
    input logic                  bridge_wr,
    input logic [CHAN_WIDTH-1:0] video_channel_enable,
    input logic                  audio_dac
);

    // I2S data held low
    dac_silent: assert property (@(posedge clk_74a) disable iff (!rst_n) !audio_dac)
        else $error("audio_dac went high");

    // host never reads and writes in one cycle
    rd_wr_exclusive: assert property (@(posedge clk_74a) disable iff (!rst_n)
        !(bridge_rd && bridge_wr))
        else $error("bridge_rd and bridge_wr high together");

    // stage 2 takes the write one clock after stage 1, new value sampled two clocks on
    chan_en_write_timing: assert property (@(posedge clk_74a) disable iff (!rst_n)
        $changed(video_channel_enable) |-> $past(bridge_wr, 2))
        else $error("video_channel_enable changed without a bridge write two cycles before");

endmodule

bind core_top core_top_properties core_top_properties_inst (
    .clk_74a              (clk_74a),
    .rst_n                (rst_n),
    .bridge_rd            (bridge_rd),
    .bridge_wr            (bridge_wr),
    .video_channel_enable (video_channel_enable),
    .audio_dac            (audio_dac)
);

`default_nettype wire

/* dv/core_top_tb.sv */
/*
 * core_top testbench
 * directed tests of the bridge register map, square window, frame counter
 * and the I2S silence clocks
 */
`default_nettype none

module core_top_tb import core_regs_pkg::*; ();

    // register tests take a few hundred cycles, lrck framing up to about
    // 2,400 and the mclk window 10,000, so 20,000 leaves ample margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int DRIVE_DELAY    = 1;

    logic        clk_74a;
    logic        rst_n;
    logic [31:0] bridge_addr;
    logic        bridge_rd;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic        vblank;
    logic [31:0] bridge_rd_data;
    logic [2:0]  video_channel_enable;
    logic        video_anim_enable;
    logic        audio_mclk;
    logic        audio_lrck;
    logic        audio_dac;

    int     errors;
    int     checks;
    int     tests_run;
    int     cycle_count;
    integer seed;

    core_top core_top_inst (.*);

    // 40 unit period
    initial begin
        clk_74a = 1'b0;
        forever #20 clk_74a = !clk_74a;
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_74a);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // bridge access and checking

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    // one-cycle write, returns once a stage-2 register has taken it (edge N+2)
    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_74a);
        #DRIVE_DELAY;
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(posedge clk_74a);
        #DRIVE_DELAY;
        bridge_wr = 1'b0;
        @(posedge clk_74a);
        @(posedge clk_74a);
        #DRIVE_DELAY;
    endtask

    // one-cycle read, data is valid at edge N+2
    task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk_74a);
        #DRIVE_DELAY;
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(posedge clk_74a);
        #DRIVE_DELAY;
        bridge_rd = 1'b0;
        @(posedge clk_74a);
        @(posedge clk_74a);
        #DRIVE_DELAY;
        data = bridge_rd_data;
    endtask

    task automatic pulse_vblank();
        @(posedge clk_74a);
        #DRIVE_DELAY;
        vblank = 1'b1;
        @(posedge clk_74a);
        #DRIVE_DELAY;
        vblank = 1'b0;
        repeat (2) @(posedge clk_74a);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    ////////////////////
    // tests

    task automatic reset_values();
        logic [31:0] data;
        int          errors_before;
        errors_before = errors;
        bridge_read(ADDR_CHAN_EN, data);
        expect_equal("chan_en", data, 32'd7);
        bridge_read(ADDR_ANIM_EN, data);
        expect_equal("anim_en", data, 32'd1);
        bridge_read(ADDR_DEBUG, data);
        expect_equal("debug", data, 32'h1200_5678);
        bridge_read(ADDR_SIGNED, data);
        expect_equal("signed", data, 32'd0);
        bridge_read({ADDR_SQUARE_WIN, 8'h00}, data);
        expect_equal("square_x", data, 32'd0);
        bridge_read({ADDR_SQUARE_WIN, 8'h04}, data);
        expect_equal("square_y", data, 32'd0);
        bridge_read(ADDR_FRAME_COUNT, data);
        expect_equal("frame_count", data, 32'd0);
        // nothing mapped here
        bridge_read(32'h00F0_0000, data);
        expect_equal("unmapped", data, 32'd0);
        expect_equal("video_channel_enable", 32'(video_channel_enable), 32'd7);
        expect_equal("video_anim_enable", 32'(video_anim_enable), 32'd1);
        report_test("reset_values", errors_before);
    endtask

    task automatic register_readback();
        logic [31:0] value;
        logic [31:0] data;
        int          errors_before;
        errors_before = errors;
        for (int i = 0; i < 4; i++) begin
            // channel enable keeps 3 bits
            value = $random(seed);
            bridge_write(ADDR_CHAN_EN, value);
            expect_equal("video_channel_enable", 32'(video_channel_enable), 32'(value[2:0]));
            bridge_read(ADDR_CHAN_EN, data);
            expect_equal("chan_en", data, 32'(value[2:0]));
            // animation enable keeps bit 0
            value = $random(seed);
            bridge_write(ADDR_ANIM_EN, value);
            expect_equal("video_anim_enable", 32'(video_anim_enable), 32'(value[0]));
            bridge_read(ADDR_ANIM_EN, data);
            expect_equal("anim_en", data, 32'(value[0]));
            // full words
            value = $random(seed);
            bridge_write(ADDR_DEBUG, value);
            bridge_read(ADDR_DEBUG, data);
            expect_equal("debug", data, value);
            value = $random(seed);
            bridge_write(ADDR_SIGNED, value);
            bridge_read(ADDR_SIGNED, data);
            expect_equal("signed", data, value);
        end
        report_test("register_readback", errors_before);
    endtask

    task automatic square_window();
        logic [31:0] data;
        int          errors_before;
        errors_before = errors;
        // upper bits dropped, 10-bit position
        bridge_write({ADDR_SQUARE_WIN, 8'h00}, 32'hABCD_0123);
        bridge_write({ADDR_SQUARE_WIN, 8'h04}, 32'h0000_F2AA);
        // offset 0x08 is not a write target
        bridge_write({ADDR_SQUARE_WIN, 8'h08}, 32'h0000_0055);
        bridge_read({ADDR_SQUARE_WIN, 8'h00}, data);
        expect_equal("square_x", data, 32'h0000_0123);
        bridge_read({ADDR_SQUARE_WIN, 8'h04}, data);
        expect_equal("square_y", data, 32'h0000_02AA);
        // other offsets read back x
        bridge_read({ADDR_SQUARE_WIN, 8'h08}, data);
        expect_equal("square_x at 0x08", data, 32'h0000_0123);
        bridge_write(ADDR_CMD_SQUARE_RST, 32'd1);
        bridge_read({ADDR_SQUARE_WIN, 8'h00}, data);
        expect_equal("square_x after reset", data, 32'd0);
        bridge_read({ADDR_SQUARE_WIN, 8'h04}, data);
        expect_equal("square_y after reset", data, 32'd0);
        report_test("square_window", errors_before);
    endtask

    task automatic frame_counting();
        logic [31:0] data;
        logic [15:0] expected;
        int          errors_before;
        errors_before = errors;
        bridge_write(ADDR_ANIM_EN, 32'd1);
        bridge_write(ADDR_CMD_FRAME_RST, 32'd1);
        expected = 16'd0;
        bridge_read(ADDR_FRAME_COUNT, data);
        expect_equal("frame_count after reset cmd", data, 32'(expected));
        // one count per vblank rise while animating
        repeat (3) begin
            pulse_vblank();
            expected = expected + 16'd1;
        end
        bridge_read(ADDR_FRAME_COUNT, data);
        expect_equal("frame_count, anim on", data, 32'(expected));
        bridge_write(ADDR_ANIM_EN, 32'd0);
        repeat (2) pulse_vblank();
        bridge_read(ADDR_FRAME_COUNT, data);
        expect_equal("frame_count, anim off", data, 32'(expected));
        bridge_write(ADDR_CMD_FRAME_INC, 32'd1);
        expected = expected + 16'd1;
        bridge_read(ADDR_FRAME_COUNT, data);
        expect_equal("frame_count after inc cmd", data, 32'(expected));
        bridge_write(ADDR_CMD_FRAME_RST, 32'd1);
        bridge_read(ADDR_FRAME_COUNT, data);
        expect_equal("frame_count after reset cmd", data, 32'd0);
        bridge_write(ADDR_ANIM_EN, 32'd1);
        report_test("frame_counting", errors_before);
    endtask

    task automatic audio_framing();
        logic   mclk_prev;
        logic   lrck_prev;
        int     rises;
        int     toggles;
        int     waited;
        int     dac_high;
        longint expect_x100;
        int     errors_before;
        errors_before = errors;
        @(posedge clk_74a);
        #DRIVE_DELAY;
        mclk_prev = audio_mclk;
        lrck_prev = audio_lrck;
        // -1 until the first lrck toggle, then 4 * 32 mclk rises per half frame
        rises   = -1;
        toggles = 0;
        waited  = 0;
        while (toggles < 3 && waited < 4000) begin
            @(posedge clk_74a);
            #DRIVE_DELAY;
            waited++;
            if (audio_mclk && !mclk_prev && rises >= 0) rises++;
            if (audio_lrck != lrck_prev) begin
                if (rises >= 0) expect_equal("mclk rises per lrck half", 32'(rises), 32'd128);
                rises = 0;
                toggles++;
            end
            mclk_prev = audio_mclk;
            lrck_prev = audio_lrck;
        end
        assert (toggles == 3) else begin
            $display("audio_lrck toggled only %0d times in %0d clocks", toggles, waited);
            errors++;
        end
        // mclk rate over a fixed window, dac data watched alongside
        rises    = 0;
        dac_high = 0;
        repeat (10000) begin
            @(posedge clk_74a);
            #DRIVE_DELAY;
            if (audio_mclk && !mclk_prev) rises++;
            if (audio_dac !== 1'b0) dac_high++;
            mclk_prev = audio_mclk;
        end
        expect_equal("audio_dac high cycles", 32'(dac_high), 32'd0);
        // 10,000 * 245760 / 1,485,000 = 1654.95, kept in hundredths
        expect_x100 = longint'(10000) * 245760 * 100 / 1485000;
        checks++;
        assert (longint'(rises) * 100 >= expect_x100 - 100
                && longint'(rises) * 100 <= expect_x100 + 100) else begin
            $display("[FAIL] t=%0t audio_mclk rises: got %0d, expected %0d.%02d +/- 1",
                     $time, rises, expect_x100 / 100, expect_x100 % 100);
            errors++;
        end
        report_test("audio_framing", errors_before);
    endtask

    ////////////////////
    // sequence

    initial begin
        seed           = 13;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        rst_n          = 1'b0;
        bridge_addr    = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        vblank         = 1'b0;
        repeat (4) @(posedge clk_74a);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        reset_values();
        register_readback();
        square_window();
        frame_counting();
        audio_framing();
        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/core_regs_pkg.sv
rtl/core_audio_pkg.sv
rtl/bridge_decode.sv
rtl/ctrl_regs.sv
rtl/frame_state.sv
rtl/audio_clock_gen.sv
rtl/core_top.sv
dv/core_top_properties.sv
dv/core_top_tb.sv

/* Makefile */
# Verilator build and run of the core_top testbench

VERILATOR ?= verilator
TOP       ?= core_top_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
